// ==== include/ram_consts.svh ====
// Geometry of the shared RAM
// Word address width, data width, byte lanes, offset bits
// Number of clients on the arbiter

`ifndef RAM_CONSTS_SVH
`define RAM_CONSTS_SVH

// Word address bits, 1024 words
`define RAM_AW 10

// Bits per RAM word
`define RAM_DW 64

// Byte lanes per word, also the write mask width
`define RAM_BYTES 8

// Byte offset bits within a word
`define RAM_OFS 3

// Fetch and load/store
`define ARB_CLIENTS 2

`endif

// ==== src/mem_pkg.sv ====
// Shared types of the memory subsystem
// acc_size_e  width of a load/store access
// mem_word_u  one RAM word with byte, halfword and word views

`include "ram_consts.svh"

package mem_pkg;

   // Load/store access width
   typedef enum logic [1:0]
   {
      ACC_BYTE  = 2'd0,
      ACC_HALF  = 2'd1,
      ACC_WORD  = 2'd2,
      ACC_DWORD = 2'd3
   } acc_size_e;

   // One RAM word, little-endian lanes
   // Byte view for the write mask and byte loads
   // Halfword and word views for the wider lanes
   typedef union packed
   {
      // Eight byte lanes
      logic [`RAM_BYTES-1:0][7:0] b;
      // Four halfword lanes
      logic [`RAM_BYTES/2-1:0][15:0] h;
      // Two word lanes
      logic [`RAM_BYTES/4-1:0][31:0] w;
   } mem_word_u;

endpackage

// ==== src/byte_ram.sv ====
// Single-port RAM
// Byte-masked write, registered read
// Read address held between read strobes

`include "ram_consts.svh"

module byte_ram
(
   input  logic                    CLK,
   input  logic [`RAM_AW-1:0]      addr,
   input  logic                    re,
   input  logic [`RAM_BYTES-1:0]   be,
   input  mem_pkg::mem_word_u      wdata,
   output mem_pkg::mem_word_u      rdata
);
   import mem_pkg::*;

   mem_word_u              mem_q [0:(1<<`RAM_AW)-1];
   mem_word_u              rdata_q;
   logic [`RAM_AW-1:0]     addr_q;
   logic [`RAM_AW-1:0]     rd_addr;

   // Last read address, kept while no read is strobed
   always_ff @(posedge CLK)
   begin
      if (re)
      begin
         addr_q <= addr;
      end
   end

   // New address on a read, held one otherwise
   assign rd_addr = re ? addr : addr_q;

   // Output register follows the held address
   always_ff @(posedge CLK)
   begin
      rdata_q <= mem_q[rd_addr];
   end

   assign rdata = rdata_q;

   // One write enable per byte lane
   always_ff @(posedge CLK)
   begin
      for (int i = 0; i < `RAM_BYTES; i++)
      begin
         if (be[i])
         begin
            mem_q[addr].b[i] <= wdata.b[i];
         end
      end
   end

endmodule

// ==== src/mem_arbiter.sv ====
// Round-robin arbiter for two RAM clients
// Grant in the request cycle, winner muxed onto the RAM
// Read owner registered to steer the response

`include "ram_consts.svh"

module mem_arbiter
(
   input  logic                    CLK,
   input  logic                    rst_n,
   // Fetch client
   input  logic                    fetch_req,
   input  logic [`RAM_AW-1:0]      fetch_addr,
   input  logic                    fetch_we,
   input  logic [`RAM_BYTES-1:0]   fetch_be,
   input  mem_pkg::mem_word_u      fetch_wdata,
   output logic                    fetch_gnt,
   output logic                    fetch_rvalid,
   // Load/store client
   input  logic                    ls_req,
   input  logic [`RAM_AW-1:0]      ls_addr,
   input  logic                    ls_we,
   input  logic [`RAM_BYTES-1:0]   ls_be,
   input  mem_pkg::mem_word_u      ls_wdata,
   output logic                    ls_gnt,
   output logic                    ls_rvalid,
   // Read data, shared by both clients
   output mem_pkg::mem_word_u      rdata,
   // RAM side
   output logic [`RAM_AW-1:0]      ram_addr,
   output logic                    ram_re,
   output logic [`RAM_BYTES-1:0]   ram_we,
   output mem_pkg::mem_word_u      ram_wdata,
   input  mem_pkg::mem_word_u      ram_rdata
);

   // Client slots in the grant vector
   localparam int CLI_FE = 0;
   localparam int CLI_LS = 1;

   logic [`ARB_CLIENTS-1:0]   gnt_vec;
   logic [`ARB_CLIENTS-1:0]   rd_owner_q;
   logic                      last_ls_q;
   logic                      pick_ls;
   logic                      sel_we;
   logic [`RAM_BYTES-1:0]     sel_be;

   // Load/store wins when alone or when fetch won last
   assign pick_ls = ls_req & (~fetch_req | ~last_ls_q);

   assign gnt_vec[CLI_FE] = fetch_req & ~pick_ls;
   assign gnt_vec[CLI_LS] = pick_ls;

   assign fetch_gnt = gnt_vec[CLI_FE];
   assign ls_gnt    = gnt_vec[CLI_LS];

   // Winner's fields onto the RAM
   assign ram_addr  = pick_ls ? ls_addr  : fetch_addr;
   assign ram_wdata = pick_ls ? ls_wdata : fetch_wdata;
   assign sel_we    = pick_ls ? ls_we    : fetch_we;
   assign sel_be    = pick_ls ? ls_be    : fetch_be;

   // Read strobe only for a granted read
   assign ram_re = (|gnt_vec) & ~sel_we;
   // Mask stays zero unless a write is granted
   assign ram_we = ((|gnt_vec) & sel_we) ? sel_be : '0;

   always_ff @(posedge CLK)
   begin
      if (!rst_n)
      begin
         last_ls_q  <= 1'b0;
         rd_owner_q <= '0;
      end
      else
      begin
         // Remember the winner for fairness
         if (|gnt_vec)
         begin
            last_ls_q <= pick_ls;
         end
         // Owner of the read now in the RAM
         rd_owner_q <= gnt_vec & {`ARB_CLIENTS{~sel_we}};
      end
   end

   // Response one cycle after the read grant
   assign fetch_rvalid = rd_owner_q[CLI_FE];
   assign ls_rvalid    = rd_owner_q[CLI_LS];
   assign rdata        = ram_rdata;

endmodule

// ==== src/fetch_seq.sv ====
// Sequential instruction-word fetcher
// Reads consecutive words from a redirect address
// Drops a response left over from before a redirect

`include "ram_consts.svh"

module fetch_seq
(
   input  logic                    CLK,
   input  logic                    rst_n,
   input  logic                    run,
   input  logic                    redirect,
   input  logic [`RAM_AW-1:0]      redirect_addr,
   // Arbiter side
   output logic                    req,
   output logic [`RAM_AW-1:0]      addr,
   input  logic                    gnt,
   input  logic                    rvalid,
   input  mem_pkg::mem_word_u      rdata,
   // Fetched word out
   output logic                    valid,
   output logic [`RAM_AW-1:0]      word_addr,
   output logic [`RAM_DW-1:0]      word
);

   logic [`RAM_AW-1:0]   next_addr_q;
   logic [`RAM_AW-1:0]   issued_addr_q;
   logic                 pend_q;
   logic                 discard_q;

   // Request again as soon as the last response lands
   assign req  = run & (~pend_q | rvalid);
   assign addr = next_addr_q;

   always_ff @(posedge CLK)
   begin
      if (!rst_n)
      begin
         next_addr_q <= '0;
         pend_q      <= 1'b0;
         discard_q   <= 1'b0;
      end
      else
      begin
         // Waiting from grant to response
         if (gnt)
         begin
            pend_q <= 1'b1;
         end
         else if (rvalid)
         begin
            pend_q <= 1'b0;
         end

         // Redirect wins over the increment
         if (redirect)
         begin
            next_addr_q <= redirect_addr;
         end
         else if (gnt)
         begin
            next_addr_q <= next_addr_q + 1'b1;
         end

         // Old-sequence read still in flight after a redirect
         if (redirect)
         begin
            discard_q <= (pend_q & ~rvalid) | gnt;
         end
         else if (rvalid)
         begin
            discard_q <= 1'b0;
         end
      end
   end

   // Address of the read in flight
   always_ff @(posedge CLK)
   begin
      if (gnt)
      begin
         issued_addr_q <= next_addr_q;
      end
   end

   // A response in the redirect cycle is stale too
   assign valid     = rvalid & ~discard_q & ~redirect;
   assign word_addr = issued_addr_q;
   assign word      = rdata;

endmodule

// ==== src/lsu_port.sv ====
// Load/store client of the RAM
// Byte, halfword, word and doubleword accesses
// Mask from size and offset, store data replicated over lanes
// Load lane extracted and sign or zero extended

`include "ram_consts.svh"

module lsu_port
(
   input  logic                            CLK,
   input  logic                            rst_n,
   // Control in
   input  logic                            start,
   input  logic                            store,
   input  mem_pkg::acc_size_e              size,
   input  logic                            sign_ext,
   input  logic [`RAM_AW+`RAM_OFS-1:0]     byte_addr,
   input  logic [`RAM_DW-1:0]              store_data,
   // Status out
   output logic                            busy,
   output logic                            done,
   output logic [`RAM_DW-1:0]              load_data,
   // Arbiter side
   output logic                            req,
   output logic [`RAM_AW-1:0]              word_addr,
   output logic                            we,
   output logic [`RAM_BYTES-1:0]           be,
   output mem_pkg::mem_word_u              wdata,
   input  logic                            gnt,
   input  logic                            rvalid,
   input  mem_pkg::mem_word_u              rdata
);
   import mem_pkg::*;

   logic                            busy_q;
   logic                            req_q;
   logic                            st_done_q;
   logic                            store_q;
   acc_size_e                       size_q;
   logic                            sext_q;
   logic [`RAM_AW+`RAM_OFS-1:0]     addr_q;
   logic [`RAM_DW-1:0]              data_q;
   logic [`RAM_OFS-1:0]             ofs;

   // Control state
   always_ff @(posedge CLK)
   begin
      if (!rst_n)
      begin
         busy_q    <= 1'b0;
         req_q     <= 1'b0;
         st_done_q <= 1'b0;
      end
      else
      begin
         // New access only while idle
         if (start && !busy_q)
         begin
            busy_q <= 1'b1;
            req_q  <= 1'b1;
         end
         else
         begin
            if (gnt)
            begin
               req_q <= 1'b0;
            end
            if (done)
            begin
               busy_q <= 1'b0;
            end
         end
         // Store completes one cycle after its grant
         st_done_q <= gnt & store_q;
      end
   end

   // Access fields captured at start
   always_ff @(posedge CLK)
   begin
      if (start && !busy_q)
      begin
         store_q <= store;
         size_q  <= size;
         sext_q  <= sign_ext;
         addr_q  <= byte_addr;
         data_q  <= store_data;
      end
   end

   assign busy = busy_q;
   // Loads finish with their read response
   assign done = rvalid | st_done_q;

   assign req       = req_q;
   assign we        = store_q;
   assign word_addr = addr_q[`RAM_AW+`RAM_OFS-1:`RAM_OFS];
   // Bits below the access size are ignored
   assign ofs       = addr_q[`RAM_OFS-1:0];

   // Byte mask and lane replication
   always_comb
   begin
      case (size_q)
         ACC_BYTE:
         begin
            be      = `RAM_BYTES'(1) << ofs;
            wdata.b = {(`RAM_BYTES){data_q[7:0]}};
         end
         ACC_HALF:
         begin
            be      = `RAM_BYTES'(2'b11) << {ofs[2:1], 1'b0};
            wdata.h = {(`RAM_BYTES/2){data_q[15:0]}};
         end
         ACC_WORD:
         begin
            be      = `RAM_BYTES'(4'hf) << {ofs[2], 2'b00};
            wdata.w = {(`RAM_BYTES/4){data_q[31:0]}};
         end
         default:
         begin
            be    = '1;
            wdata = data_q;
         end
      endcase
   end

   // Lane pick, little-endian, then extension
   always_comb
   begin
      case (size_q)
         ACC_BYTE:
            load_data = {{(`RAM_DW-8){sext_q & rdata.b[ofs][7]}}, rdata.b[ofs]};
         ACC_HALF:
            load_data = {{(`RAM_DW-16){sext_q & rdata.h[ofs[2:1]][15]}},
                         rdata.h[ofs[2:1]]};
         ACC_WORD:
            load_data = {{(`RAM_DW-32){sext_q & rdata.w[ofs[2]][31]}},
                         rdata.w[ofs[2]]};
         default:
            load_data = rdata;
      endcase
   end

endmodule

// ==== src/mem_subsys_top.sv ====
// Memory subsystem top level
// Shared RAM, round-robin arbiter
// Instruction fetcher and load/store port as clients

`include "ram_consts.svh"

module mem_subsys_top
(
   input  logic                            CLK,
   input  logic                            rst_n,
   // Fetch side
   input  logic                            fe_run,
   input  logic                            fe_redirect,
   input  logic [`RAM_AW-1:0]              fe_redirect_addr,
   output logic                            fe_valid,
   output logic [`RAM_AW-1:0]              fe_addr,
   output logic [`RAM_DW-1:0]              fe_word,
   // Load/store side
   input  logic                            ls_start,
   input  logic                            ls_store,
   input  mem_pkg::acc_size_e              ls_size,
   input  logic                            ls_signed,
   input  logic [`RAM_AW+`RAM_OFS-1:0]     ls_addr,
   input  logic [`RAM_DW-1:0]              ls_wdata,
   output logic                            ls_busy,
   output logic                            ls_done,
   output logic [`RAM_DW-1:0]              ls_rdata
);
   import mem_pkg::*;

   // Fetch client wires
   logic                     fc_req;
   logic [`RAM_AW-1:0]       fc_addr;
   logic                     fc_gnt;
   logic                     fc_rvalid;
   // Load/store client wires
   logic                     lc_req;
   logic [`RAM_AW-1:0]       lc_addr;
   logic                     lc_we;
   logic [`RAM_BYTES-1:0]    lc_be;
   mem_word_u                lc_wdata;
   logic                     lc_gnt;
   logic                     lc_rvalid;
   // Shared read data and RAM port
   mem_word_u                cli_rdata;
   logic [`RAM_AW-1:0]       ram_addr;
   logic                     ram_re;
   logic [`RAM_BYTES-1:0]    ram_we;
   mem_word_u                ram_wdata;
   mem_word_u                ram_rdata;

   byte_ram u_ram
   (
      .CLK     (CLK),
      .addr    (ram_addr),
      .re      (ram_re),
      .be      (ram_we),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

   // Fetch never writes
   mem_arbiter u_arb
   (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .fetch_req     (fc_req),
      .fetch_addr    (fc_addr),
      .fetch_we      (1'b0),
      .fetch_be      ('0),
      .fetch_wdata   ('0),
      .fetch_gnt     (fc_gnt),
      .fetch_rvalid  (fc_rvalid),
      .ls_req        (lc_req),
      .ls_addr       (lc_addr),
      .ls_we         (lc_we),
      .ls_be         (lc_be),
      .ls_wdata      (lc_wdata),
      .ls_gnt        (lc_gnt),
      .ls_rvalid     (lc_rvalid),
      .rdata         (cli_rdata),
      .ram_addr      (ram_addr),
      .ram_re        (ram_re),
      .ram_we        (ram_we),
      .ram_wdata     (ram_wdata),
      .ram_rdata     (ram_rdata)
   );

   fetch_seq u_fetch
   (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .run           (fe_run),
      .redirect      (fe_redirect),
      .redirect_addr (fe_redirect_addr),
      .req           (fc_req),
      .addr          (fc_addr),
      .gnt           (fc_gnt),
      .rvalid        (fc_rvalid),
      .rdata         (cli_rdata),
      .valid         (fe_valid),
      .word_addr     (fe_addr),
      .word          (fe_word)
   );

   lsu_port u_lsu
   (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .start         (ls_start),
      .store         (ls_store),
      .size          (ls_size),
      .sign_ext      (ls_signed),
      .byte_addr     (ls_addr),
      .store_data    (ls_wdata),
      .busy          (ls_busy),
      .done          (ls_done),
      .load_data     (ls_rdata),
      .req           (lc_req),
      .word_addr     (lc_addr),
      .we            (lc_we),
      .be            (lc_be),
      .wdata         (lc_wdata),
      .gnt           (lc_gnt),
      .rvalid        (lc_rvalid),
      .rdata         (cli_rdata)
   );

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset
// CLK with a period of 4
// rst_n held low for the first five rising edges

module tb_clock
(
   output logic CLK,
   output logic rst_n
);

   // Free-running clock
   initial
   begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // Synchronous reset, released on an edge
   initial
   begin
      rst_n = 1'b0;
      repeat (5) @(posedge CLK);
      rst_n <= 1'b1;
   end

endmodule

// ==== tests/tb_mem_subsys.sv ====
// Testbench for the memory subsystem
// Byte-array reference model updated at each store completion
// Concurrent assertions on loads, fetch words, redirects and latency
// Directed lane tests, then random accesses with fetch running
// Watchdog sized from the operation count

`include "ram_consts.svh"

module tb_mem_subsys;
   import mem_pkg::*;

   localparam int WORDS      = 1 << `RAM_AW;
   localparam int N_DIRECTED = 48;
   localparam int N_RAND     = 400;
   // Zero fill, directed, random, plus the fetch-only phase
   localparam int N_OPS      = WORDS + N_DIRECTED + N_RAND + 16;
   localparam int WD_CYCLES  = N_OPS * 8 + 100;

   logic                            CLK;
   logic                            rst_n;
   // DUT inputs
   logic                            fe_run;
   logic                            fe_redirect;
   logic [`RAM_AW-1:0]              fe_redirect_addr;
   logic                            ls_start;
   logic                            ls_store;
   acc_size_e                       ls_size;
   logic                            ls_signed;
   logic [`RAM_AW+`RAM_OFS-1:0]     ls_addr;
   logic [`RAM_DW-1:0]              ls_wdata;
   // DUT outputs
   logic                            fe_valid;
   logic [`RAM_AW-1:0]              fe_addr;
   logic [`RAM_DW-1:0]              fe_word;
   logic                            ls_busy;
   logic                            ls_done;
   logic [`RAM_DW-1:0]              ls_rdata;

   // Access in progress, as issued
   logic                            cur_store;
   acc_size_e                       cur_size;
   logic                            cur_signed;
   logic [`RAM_AW+`RAM_OFS-1:0]     cur_addr;
   logic [`RAM_DW-1:0]              cur_wdata;
   int                              acc_bytes;
   logic [`RAM_AW+`RAM_OFS-1:0]     acc_base;

   // Reference memory, one entry per byte
   logic [7:0]                      model [0:WORDS*`RAM_BYTES-1];
   logic [`RAM_DW-1:0]              exp_load;
   logic [`RAM_DW-1:0]              exp_fe_word;
   logic [`RAM_AW-1:0]              exp_fe_addr;
   logic                            redir_d;
   // Cycles since the last redirect, saturating
   logic [2:0]                      redir_age;
   // Fetch word seen since the last redirect
   logic                            fe_seen;
   int                              ls_wait;
   logic                            stim_started;
   logic                            rand_done;

   tb_clock u_clk
   (
      .CLK   (CLK),
      .rst_n (rst_n)
   );

   mem_subsys_top uut
   (
      .CLK              (CLK),
      .rst_n            (rst_n),
      .fe_run           (fe_run),
      .fe_redirect      (fe_redirect),
      .fe_redirect_addr (fe_redirect_addr),
      .fe_valid         (fe_valid),
      .fe_addr          (fe_addr),
      .fe_word          (fe_word),
      .ls_start         (ls_start),
      .ls_store         (ls_store),
      .ls_size          (ls_size),
      .ls_signed        (ls_signed),
      .ls_addr          (ls_addr),
      .ls_wdata         (ls_wdata),
      .ls_busy          (ls_busy),
      .ls_done          (ls_done),
      .ls_rdata         (ls_rdata)
   );

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   // Size in bytes, address aligned down to it
   assign acc_bytes = 1 << cur_size;
   assign acc_base  = cur_addr & ~((`RAM_AW+`RAM_OFS)'(acc_bytes - 1));

   // Little-endian bytes from the model, then extension
   always_comb
   begin
      exp_load = '0;
      for (int i = 0; i < `RAM_BYTES; i++)
      begin
         if (i < acc_bytes)
            exp_load[8*i +: 8] = model[acc_base + i];
         else if (cur_signed && exp_load[8*acc_bytes-1])
            exp_load[8*i +: 8] = 8'hff;
      end
   end

   // Whole word the fetcher should present
   always_comb
   begin
      for (int i = 0; i < `RAM_BYTES; i++)
         exp_fe_word[8*i +: 8] = model[{exp_fe_addr, `RAM_OFS'(i)}];
   end

   // Store lands in the model when it completes
   always @(posedge CLK)
   begin
      if (ls_done && cur_store)
      begin
         for (int i = 0; i < `RAM_BYTES; i++)
         begin
            if (i < acc_bytes)
               model[acc_base + i] <= cur_wdata[8*i +: 8];
         end
      end
   end

   // Expected fetch address, latency counter, redirect delay
   always @(posedge CLK)
   begin
      if (!rst_n)
      begin
         exp_fe_addr <= '0;
         redir_d     <= 1'b0;
         redir_age   <= '0;
         fe_seen     <= 1'b0;
         ls_wait     <= 0;
      end
      else
      begin
         if (fe_redirect)
            exp_fe_addr <= fe_redirect_addr;
         else if (fe_valid)
            exp_fe_addr <= exp_fe_addr + 1'b1;
         redir_d <= fe_redirect;
         // Progress of the new sequence
         if (fe_redirect)
         begin
            redir_age <= 3'd1;
            fe_seen   <= 1'b0;
         end
         else
         begin
            if (redir_age != 3'd0 && redir_age != 3'd7)
               redir_age <= redir_age + 1'b1;
            if (fe_valid)
               fe_seen <= 1'b1;
         end
         // Cycles since the accepted start
         if (ls_start && !ls_busy)
            ls_wait <= 1;
         else if (ls_busy)
            ls_wait <= ls_wait + 1;
         else
            ls_wait <= 0;
      end
   end

   // Quiet outputs between reset and the first stimulus
   a_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
      !stim_started |-> !fe_valid && !ls_done && !ls_busy)
      else report_fail("outputs active after reset before any stimulus");

   a_load: assert property (@(posedge CLK) disable iff (!rst_n)
      ls_done && !cur_store |-> ls_rdata == exp_load)
      else report_fail($sformatf("mismatch at time %0t: load data %h, expected %h",
                                 $time, $sampled(ls_rdata), $sampled(exp_load)));

   a_fe_addr: assert property (@(posedge CLK) disable iff (!rst_n)
      fe_valid |-> fe_addr == exp_fe_addr)
      else report_fail($sformatf("mismatch at time %0t: fetch address %h, expected %h",
                                 $time, $sampled(fe_addr), $sampled(exp_fe_addr)));

   a_fe_word: assert property (@(posedge CLK) disable iff (!rst_n)
      fe_valid |-> fe_word == exp_fe_word)
      else report_fail($sformatf("mismatch at time %0t: fetch word %h, expected %h",
                                 $time, $sampled(fe_word), $sampled(exp_fe_word)));

   // Stale response falls in the redirect cycle or the one after
   a_no_stale: assert property (@(posedge CLK) disable iff (!rst_n)
      fe_redirect || redir_d |-> !fe_valid)
      else report_fail("fetch word from the old sequence delivered after a redirect");

   // First new word two cycles after a redirect, one more behind a load/store grant
   a_fe_resume: assert property (@(posedge CLK) disable iff (!rst_n)
      fe_run && redir_age == 3'd3 |-> fe_seen || fe_valid)
      else report_fail("fetch delivered no word within three cycles of a redirect");

   a_latency: assert property (@(posedge CLK) disable iff (!rst_n)
      ls_done |-> ls_wait == 2 || ls_wait == 3)
      else report_fail($sformatf("mismatch at time %0t: ls_done %0d cycles after start",
                                 $time, $sampled(ls_wait)));

   a_in_time: assert property (@(posedge CLK) disable iff (!rst_n)
      ls_busy |-> ls_wait <= 3)
      else report_fail("load/store access still busy three cycles after its start");

   // One access, started on the current edge
   task automatic lsu_access
   (
      input logic                            store,
      input acc_size_e                       size,
      input logic                            sgn,
      input logic [`RAM_AW+`RAM_OFS-1:0]     addr,
      input logic [`RAM_DW-1:0]              data
   );
      int n;
      ls_start   <= 1'b1;
      ls_store   <= store;
      ls_size    <= size;
      ls_signed  <= sgn;
      ls_addr    <= addr;
      ls_wdata   <= data;
      cur_store  <= store;
      cur_size   <= size;
      cur_signed <= sgn;
      cur_addr   <= addr;
      cur_wdata  <= data;
      @(posedge CLK);
      ls_start <= 1'b0;
      n = 0;
      do
      begin
         @(posedge CLK);
         n++;
      end
      while (!ls_done && n < 8);
      if (!ls_done)
         report_fail("load/store access never completed");
   endtask

   task automatic pulse_redirect(input logic [`RAM_AW-1:0] addr);
      fe_redirect      <= 1'b1;
      fe_redirect_addr <= addr;
      @(posedge CLK);
      fe_redirect <= 1'b0;
   endtask

   // Watchdog
   initial
   begin
      repeat (WD_CYCLES) @(posedge CLK);
      report_fail("watchdog expired before the tests finished");
   end

   initial
   begin
      int unsigned gap;
      void'($urandom(17753));
      fe_run           = 1'b0;
      fe_redirect      = 1'b0;
      fe_redirect_addr = '0;
      ls_start         = 1'b0;
      ls_store         = 1'b0;
      ls_size          = ACC_BYTE;
      ls_signed        = 1'b0;
      ls_addr          = '0;
      ls_wdata         = '0;
      cur_store        = 1'b0;
      cur_size         = ACC_BYTE;
      cur_signed       = 1'b0;
      cur_addr         = '0;
      cur_wdata        = '0;
      stim_started     = 1'b0;
      rand_done        = 1'b0;

      // Idle window after reset
      @(posedge CLK);
      while (!rst_n)
         @(posedge CLK);
      repeat (4) @(posedge CLK);
      stim_started <= 1'b1;

      // Clear the whole RAM, model follows
      for (int w = 0; w < WORDS; w++)
         lsu_access(1'b1, ACC_DWORD, 1'b0, (`RAM_AW+`RAM_OFS)'(w * 8), '0);

      // Mixed-sign pattern in word 5
      lsu_access(1'b1, ACC_DWORD, 1'b0, 13'h028, 64'h7f80_01fe_8c73_2a95);
      for (int o = 0; o < 8; o++)
      begin
         lsu_access(1'b0, ACC_BYTE, 1'b0, 13'h028 + 13'(o), '0);
         lsu_access(1'b0, ACC_BYTE, 1'b1, 13'h028 + 13'(o), '0);
         // Odd offsets check that low bits are ignored
         lsu_access(1'b0, ACC_HALF, o[0], 13'h028 + 13'(o), '0);
         lsu_access(1'b0, ACC_WORD, o[1], 13'h028 + 13'(o), '0);
      end
      lsu_access(1'b0, ACC_DWORD, 1'b1, 13'h02b, '0);

      // Partial stores, each followed by a full-word look
      lsu_access(1'b1, ACC_BYTE, 1'b0, 13'h02d, 64'hffff_ffff_ffff_ff5a);
      lsu_access(1'b0, ACC_DWORD, 1'b0, 13'h028, '0);
      lsu_access(1'b1, ACC_HALF, 1'b0, 13'h02b, 64'h0000_0000_0000_beef);
      lsu_access(1'b0, ACC_DWORD, 1'b0, 13'h028, '0);
      lsu_access(1'b1, ACC_WORD, 1'b0, 13'h02e, 64'hcafe_f00d_1234_5678);
      lsu_access(1'b0, ACC_DWORD, 1'b0, 13'h028, '0);

      // Fetch alone, redirected while a read is in flight
      pulse_redirect(10'h004);
      fe_run <= 1'b1;
      repeat (12) @(posedge CLK);
      pulse_redirect(10'h200);
      repeat (12) @(posedge CLK);
      pulse_redirect(10'h003);

      // Random traffic against a running fetcher
      fork
         begin
            for (int k = 0; k < N_RAND; k++)
            begin
               lsu_access(1'($urandom_range(0, 1)), acc_size_e'($urandom_range(0, 3)),
                          1'($urandom_range(0, 1)), 13'($urandom_range(0, 511)),
                          {$urandom, $urandom});
            end
            rand_done = 1'b1;
         end
         begin
            while (!rand_done)
            begin
               gap = $urandom_range(3, 15);
               repeat (gap) @(posedge CLK);
               pulse_redirect(10'($urandom_range(0, 63)));
            end
         end
      join

      // Let the last fetch response drain
      fe_run <= 1'b0;
      repeat (4) @(posedge CLK);
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
src/mem_pkg.sv
src/byte_ram.sv
src/mem_arbiter.sv
src/fetch_seq.sv
src/lsu_port.sv
src/mem_subsys_top.sv
tests/tb_clock.sv
tests/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/mem_pkg.sv
      - src/byte_ram.sv
      - src/mem_arbiter.sv
      - src/fetch_seq.sv
      - src/lsu_port.sv
      - src/mem_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock.sv
      - tests/tb_mem_subsys.sv
